/* csh_consts.svh */
`ifndef CSH_CONSTS_SVH
`define CSH_CONSTS_SVH

// Cache geometry
`define CSH_WAYS 4

// Diagnostic readout
`define CSH_DIAG_SEL_W 3
`define CSH_DIAG_W 8

// Row numbers on the diagnostic select
`define CSH_DIAG_ROW_STATE 3'd0
`define CSH_DIAG_ROW_LOOKUP 3'd1

// Non-EBOX cycles (MB, channel, CCA) run a fixed length
`define CSH_AUX_LEN 3
`define CSH_AUX_CNT_W 2

`endif

/* cshCyclePkg.sv */
`include "csh_consts.svh"

package cshCyclePkg;

  // One-hot kind of the cycle in progress, zero when idle
  typedef struct packed {
    logic mb;
    logic chan;
    logic ebox;
    logic cca;
  } cycKindT;

  // EBOX reference timing
  typedef enum logic [2:0] {
    eboxIdle = 3'd0,
    eboxT0 = 3'd1,
    eboxT1 = 3'd2,
    eboxT2 = 3'd3,
    eboxT3 = 3'd4
  } eboxStateT;

  // Per-way flags from the directory
  typedef logic [`CSH_WAYS-1:0] wayVecT;

  // Way number picked for replacement
  typedef logic [$clog2(`CSH_WAYS)-1:0] lruT;

endpackage

/* cshDiagPkg.sv */
`include "csh_consts.svh"

package cshDiagPkg;

  // Row select from the diagnostic bus
  typedef logic [`CSH_DIAG_SEL_W-1:0] diagSelT;

  // State row, MSB first
  typedef struct packed {
    logic readyToGo;
    logic coreRdReq;
    logic mb;
    logic chan;
    logic ebox;
    logic cca;
    logic [1:0] spare;
  } diagRowT;

endpackage

/* cshArbiter.sv */
`timescale 1ns/1ps

module cshArbiter
  import cshCyclePkg::*;
(
  input logic clk,
  input logic rstN,
  input logic mbReq,
  input logic chanReq,
  input logic eboxReq,
  input logic ccaReq,
  input logic coreBusy,
  input logic readyToGo,
  output cycKindT cycKind,
  output logic grantAny
);

  logic eboxReqEn;
  logic ccaReqEn;
  cycKindT grant;

  // EBOX and CCA wait while the core is tied up
  always_comb begin
    eboxReqEn = eboxReq & ~coreBusy;
    ccaReqEn = ccaReq & ~coreBusy;
  end

  // Fixed priority: MB, channel, EBOX, CCA
  always_comb begin
    grant = '0;
    if (readyToGo) begin
      if (mbReq) begin
        grant.mb = 1'b1;
      end else if (chanReq) begin
        grant.chan = 1'b1;
      end else if (eboxReqEn) begin
        grant.ebox = 1'b1;
      end else if (ccaReqEn) begin
        grant.cca = 1'b1;
      end
    end
  end

  assign grantAny = |grant;

  // Cycle type held until the cache is ready again
  // Loads zero when ready with nothing granted
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cycKind <= '0;
    end else if (readyToGo) begin
      cycKind <= grant;
    end
  end

endmodule

/* cshWayMatch.sv */
`timescale 1ns/1ps
`include "csh_consts.svh"

module cshWayMatch
  import cshCyclePkg::*;
(
  input wayVecT wayValidMatch,
  input wayVecT wayWordValid,
  input wayVecT wayWritten,
  input lruT lruVictim,
  output logic anyMatch,
  output logic rdFound,
  output logic victimWritten
);

  wayVecT foundVec;
  wayVecT victimSel;
  wayVecT victimDirty;

  // Per-way terms
  always_comb begin
    for (int w = 0; w < `CSH_WAYS; w++) begin
      // Tag matched and the addressed word is present
      foundVec[w] = wayValidMatch[w] & wayWordValid[w];
      // One-hot decode of the replacement way
      victimSel[w] = (lruVictim == lruT'(w));
      victimDirty[w] = victimSel[w] & wayWritten[w];
    end
  end

  // Reductions seen by the sequencer
  always_comb begin
    anyMatch = |wayValidMatch;
    rdFound = |foundVec;
    // Victim must be written back before it can be replaced
    victimWritten = |victimDirty;
  end

endmodule

/* cshCoreRead.sv */
`timescale 1ns/1ps

module cshCoreRead (
  input logic clk,
  input logic rstN,
  input logic startRead,
  input logic coreDataValid,
  output logic coreRdReq,
  output logic coreRdDone
);

  logic dataSeen;

  // Data accepted only against an open request
  assign dataSeen = coreRdReq & coreDataValid;

  // Request stays up for the whole memory latency
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      coreRdReq <= 1'b0;
    end else if (startRead) begin
      coreRdReq <= 1'b1;
    end else if (dataSeen) begin
      coreRdReq <= 1'b0;
    end
  end

  // Completion pulse ends the miss
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      coreRdDone <= 1'b0;
    end else begin
      coreRdDone <= dataSeen;
    end
  end

endmodule

/* cshControl.sv */
`timescale 1ns/1ps
`include "csh_consts.svh"

module cshControl
  import cshCyclePkg::*;
(
  input logic clk,
  input logic rstN,
  input cycKindT cycKind,
  input logic grantAny,
  input logic vmaRead,
  input logic coreBusy,
  input logic anyMatch,
  input logic rdFound,
  input logic victimWritten,
  input logic coreRdDone,
  output logic readyToGo,
  output eboxStateT eboxState,
  output logic startRead,
  output logic mboxResp,
  output logic cacheWrEn,
  output logic writebackReq,
  output logic eboxRetryReq
);

  logic cycStart;
  logic auxActive;
  logic [`CSH_AUX_CNT_W-1:0] auxCnt;
  logic leaveT2;
  logic rdHit;
  logic wrFill;
  logic wrBack;
  logic rdMissQ;
  logic mboxRespQ;
  logic cacheWrEnQ;

  // Lookup decisions are taken on the way out of t2
  always_comb begin
    leaveT2 = (eboxState == eboxT2) & ~coreBusy;
    rdHit = leaveT2 & vmaRead & rdFound;
    startRead = leaveT2 & vmaRead & ~rdFound;
    wrBack = leaveT2 & ~vmaRead & ~anyMatch & victimWritten;
    // Write hit, or miss into a clean victim
    wrFill = leaveT2 & ~vmaRead & (anyMatch | ~victimWritten);
    auxActive = ~readyToGo & (cycKind.mb | cycKind.chan | cycKind.cca);
  end

  // EBOX timing chain, held in t2 by a busy core
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      eboxState <= eboxIdle;
      cycStart <= 1'b0;
    end else begin
      cycStart <= grantAny;
      case (eboxState)
        eboxIdle: if (cycStart && cycKind.ebox) eboxState <= eboxT0;
        eboxT0: eboxState <= eboxT1;
        eboxT1: eboxState <= eboxT2;
        eboxT2: if (!coreBusy) eboxState <= eboxT3;
        eboxT3: eboxState <= eboxIdle;
        default: eboxState <= eboxIdle;
      endcase
    end
  end

  // One-cycle strobes, high during t3
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mboxRespQ <= 1'b0;
      cacheWrEnQ <= 1'b0;
      writebackReq <= 1'b0;
      eboxRetryReq <= 1'b0;
      rdMissQ <= 1'b0;
    end else begin
      mboxRespQ <= rdHit;
      cacheWrEnQ <= wrFill;
      writebackReq <= wrBack;
      eboxRetryReq <= writebackReq;
      rdMissQ <= startRead;
    end
  end

  // Returning core data answers the EBOX and fills the line at once
  assign mboxResp = mboxRespQ | coreRdDone;
  assign cacheWrEn = cacheWrEnQ | coreRdDone;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      readyToGo <= 1'b1;
      auxCnt <= '0;
    end else if (grantAny) begin
      readyToGo <= 1'b0;
      auxCnt <= `CSH_AUX_CNT_W'(`CSH_AUX_LEN - 1);
    end else if (auxActive) begin
      if (auxCnt == '0) begin
        readyToGo <= 1'b1;
      end else begin
        auxCnt <= auxCnt - 1'b1;
      end
    end else if ((eboxState == eboxT3 && !rdMissQ) || coreRdDone) begin
      // A read miss keeps the cache busy until core data is back
      readyToGo <= 1'b1;
    end
  end

endmodule

/* cshDiagMux.sv */
`timescale 1ns/1ps
`include "csh_consts.svh"

module cshDiagMux
  import cshCyclePkg::*, cshDiagPkg::*;
(
  input logic clk,
  input logic rstN,
  input logic diagEn,
  input diagSelT diagSel,
  input cycKindT cycKind,
  input eboxStateT eboxState,
  input logic readyToGo,
  input logic coreRdReq,
  input logic anyMatch,
  input logic rdFound,
  input logic victimWritten,
  output logic [`CSH_DIAG_W-1:0] diagData
);

  diagRowT stateRow;
  logic [`CSH_DIAG_W-1:0] lookupRow;
  logic [`CSH_DIAG_W-1:0] selRow;
  logic [`CSH_DIAG_W-1:0] rowQ;

  always_comb begin
    stateRow.readyToGo = readyToGo;
    stateRow.coreRdReq = coreRdReq;
    stateRow.mb = cycKind.mb;
    stateRow.chan = cycKind.chan;
    stateRow.ebox = cycKind.ebox;
    stateRow.cca = cycKind.cca;
    stateRow.spare = '0;
    // Lookup row, timing state in the low bits
    lookupRow = {2'b00, victimWritten, rdFound, anyMatch, eboxState};
    case (diagSel)
      `CSH_DIAG_ROW_STATE: selRow = stateRow;
      `CSH_DIAG_ROW_LOOKUP: selRow = lookupRow;
      default: selRow = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rowQ <= '0;
    end else begin
      rowQ <= selRow;
    end
  end

  assign diagData = diagEn ? rowQ : '0;

endmodule

/* cshTop.sv */
`timescale 1ns/1ps
`include "csh_consts.svh"

module cshTop
  import cshCyclePkg::*, cshDiagPkg::*;
(
  input logic clk,
  input logic rstN,
  input logic mbReq,
  input logic chanReq,
  input logic eboxReq,
  input logic ccaReq,
  input logic vmaRead,
  input logic coreBusy,
  input logic coreDataValid,
  input wayVecT wayValidMatch,
  input wayVecT wayWordValid,
  input wayVecT wayWritten,
  input lruT lruVictim,
  input logic diagEn,
  input diagSelT diagSel,
  output logic readyToGo,
  output cycKindT cycKind,
  output logic mboxResp,
  output logic cacheWrEn,
  output logic writebackReq,
  output logic eboxRetryReq,
  output logic coreRdReq,
  output logic [`CSH_DIAG_W-1:0] diagData
);

  logic grantAny;
  eboxStateT eboxState;
  logic startRead;
  logic coreRdDone;
  logic anyMatch;
  logic rdFound;
  logic victimWritten;

  cshArbiter arbiter_i (
    .clk(clk),
    .rstN(rstN),
    .mbReq(mbReq),
    .chanReq(chanReq),
    .eboxReq(eboxReq),
    .ccaReq(ccaReq),
    .coreBusy(coreBusy),
    .readyToGo(readyToGo),
    .cycKind(cycKind),
    .grantAny(grantAny)
  );

  cshWayMatch wayMatch_i (
    .wayValidMatch(wayValidMatch),
    .wayWordValid(wayWordValid),
    .wayWritten(wayWritten),
    .lruVictim(lruVictim),
    .anyMatch(anyMatch),
    .rdFound(rdFound),
    .victimWritten(victimWritten)
  );

  cshControl control_i (
    .clk(clk),
    .rstN(rstN),
    .cycKind(cycKind),
    .grantAny(grantAny),
    .vmaRead(vmaRead),
    .coreBusy(coreBusy),
    .anyMatch(anyMatch),
    .rdFound(rdFound),
    .victimWritten(victimWritten),
    .coreRdDone(coreRdDone),
    .readyToGo(readyToGo),
    .eboxState(eboxState),
    .startRead(startRead),
    .mboxResp(mboxResp),
    .cacheWrEn(cacheWrEn),
    .writebackReq(writebackReq),
    .eboxRetryReq(eboxRetryReq)
  );

  cshCoreRead coreRead_i (
    .clk(clk),
    .rstN(rstN),
    .startRead(startRead),
    .coreDataValid(coreDataValid),
    .coreRdReq(coreRdReq),
    .coreRdDone(coreRdDone)
  );

  cshDiagMux diagMux_i (
    .clk(clk),
    .rstN(rstN),
    .diagEn(diagEn),
    .diagSel(diagSel),
    .cycKind(cycKind),
    .eboxState(eboxState),
    .readyToGo(readyToGo),
    .coreRdReq(coreRdReq),
    .anyMatch(anyMatch),
    .rdFound(rdFound),
    .victimWritten(victimWritten),
    .diagData(diagData)
  );

endmodule

/* cshTopTb.sv */
`timescale 1ns/1ps
`include "csh_consts.svh"

module cshTopTb
  import cshCyclePkg::*, cshDiagPkg::*;
;

  localparam int NumTxn = 400;
  localparam int CycleLimit = 20 * NumTxn + 200;
  localparam int Seed = 3597;

  logic clk;
  logic rstN;
  logic mbReq;
  logic chanReq;
  logic eboxReq;
  logic ccaReq;
  logic vmaRead;
  logic coreBusy;
  logic coreDataValid;
  wayVecT wayValidMatch;
  wayVecT wayWordValid;
  wayVecT wayWritten;
  lruT lruVictim;
  logic diagEn;
  diagSelT diagSel;
  logic readyToGo;
  cycKindT cycKind;
  logic mboxResp;
  logic cacheWrEn;
  logic writebackReq;
  logic eboxRetryReq;
  logic coreRdReq;
  logic [`CSH_DIAG_W-1:0] diagData;

  // Reference model state
  logic mReady;
  cycKindT mKind;
  eboxStateT mState;
  logic mEboxGo;
  int mAuxAge;
  logic mResp;
  logic mWr;
  logic mWb;
  logic mRetry;
  logic mCoreReq;
  logic mDone;
  logic mMissWait;
  logic [`CSH_DIAG_W-1:0] mRowQ;

  int errCount;
  int checkCount;
  int txnCount;
  int cycleCount;
  int nRdHit;
  int nWrite;
  int nRdMiss;
  int nWb;
  int nStall;
  int nAux;
  int unsigned seedVal;

  cshTop cshTop_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run limit scales with the number of transactions
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", CycleLimit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic checkVal(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("Error: %s actual 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic requireSeen(input string what, input int count);
    if (count == 0) begin
      errCount++;
      $display("Error: the run never exercised %s", what);
    end
  endtask

  task automatic resetModel();
    mReady = 1'b1;
    mKind = '0;
    mState = eboxIdle;
    mEboxGo = 1'b0;
    mAuxAge = 0;
    mResp = 1'b0;
    mWr = 1'b0;
    mWb = 1'b0;
    mRetry = 1'b0;
    mCoreReq = 1'b0;
    mDone = 1'b0;
    mMissWait = 1'b0;
    mRowQ = '0;
  endtask

  // One clock edge of the model, from the inputs applied before it
  task automatic stepModel();
    cycKindT grant;
    logic anyM;
    logic found;
    logic vicW;
    logic leave;
    logic rdMiss;
    logic auxOn;
    logic nReady;
    eboxStateT nState;
    diagRowT row0;
    logic [`CSH_DIAG_W-1:0] row1;
    grant = '0;
    if (mReady) begin
      if (mbReq) grant.mb = 1'b1;
      else if (chanReq) grant.chan = 1'b1;
      else if (eboxReq && !coreBusy) grant.ebox = 1'b1;
      else if (ccaReq && !coreBusy) grant.cca = 1'b1;
    end
    anyM = |wayValidMatch;
    found = |(wayValidMatch & wayWordValid);
    vicW = wayWritten[lruVictim];
    leave = (mState == eboxT2) && !coreBusy;
    rdMiss = leave && vmaRead && !found;
    auxOn = !mReady && (mKind.mb || mKind.chan || mKind.cca);
    if (mState == eboxT2 && coreBusy) nStall++;

    nReady = mReady;
    if (grant != '0) nReady = 1'b0;
    else if (auxOn) nReady = (mAuxAge + 1 == `CSH_AUX_LEN);
    else if ((mState == eboxT3 && !mMissWait) || mDone) nReady = 1'b1;

    case (mState)
      eboxIdle: nState = mEboxGo ? eboxT0 : eboxIdle;
      eboxT0: nState = eboxT1;
      eboxT1: nState = eboxT2;
      eboxT2: nState = coreBusy ? eboxT2 : eboxT3;
      default: nState = eboxIdle;
    endcase

    row0 = '0;
    row0.readyToGo = mReady;
    row0.coreRdReq = mCoreReq;
    row0.mb = mKind.mb;
    row0.chan = mKind.chan;
    row0.ebox = mKind.ebox;
    row0.cca = mKind.cca;
    row1 = '0;
    row1[2:0] = mState;
    row1[3] = anyM;
    row1[4] = found;
    row1[5] = vicW;
    if (diagSel == 0) mRowQ = row0;
    else if (diagSel == 1) mRowQ = row1;
    else mRowQ = '0;

    if (mDone) mMissWait = 1'b0;
    if (rdMiss) mMissWait = 1'b1;
    mRetry = mWb;
    mWb = leave && !vmaRead && !anyM && vicW;
    mResp = leave && vmaRead && found;
    mWr = leave && !vmaRead && (anyM || !vicW);
    mDone = mCoreReq && coreDataValid;
    if (rdMiss) mCoreReq = 1'b1;
    else if (mDone) mCoreReq = 1'b0;

    if (grant != '0) mAuxAge = 0;
    else if (auxOn) mAuxAge++;
    if (mReady) mKind = grant;
    mEboxGo = grant.ebox;
    mReady = nReady;
    mState = nState;

    if (grant != '0) txnCount++;
    if (grant.mb || grant.chan || grant.cca) nAux++;
    if (mResp) nRdHit++;
    if (mWr) nWrite++;
    if (rdMiss) nRdMiss++;
    if (mWb) nWb++;
  endtask

  task automatic checkOutputs();
    logic [`CSH_DIAG_W-1:0] expDiag;
    expDiag = diagEn ? mRowQ : '0;
    checkVal("readyToGo", 32'(readyToGo), 32'(mReady));
    checkVal("cycKind", 32'(cycKind), 32'(mKind));
    checkVal("mboxResp", 32'(mboxResp), 32'(mResp | mDone));
    checkVal("cacheWrEn", 32'(cacheWrEn), 32'(mWr | mDone));
    checkVal("writebackReq", 32'(writebackReq), 32'(mWb));
    checkVal("eboxRetryReq", 32'(eboxRetryReq), 32'(mRetry));
    checkVal("coreRdReq", 32'(coreRdReq), 32'(mCoreReq));
    checkVal("diagData", 32'(diagData), 32'(expDiag));
  endtask

  task automatic driveRandom(input logic withReq);
    int r;
    mbReq = withReq && ($urandom % 100 < 12);
    chanReq = withReq && ($urandom % 100 < 12);
    eboxReq = withReq && ($urandom % 100 < 60);
    ccaReq = withReq && ($urandom % 100 < 20);
    coreBusy = ($urandom % 100 < 25);
    coreDataValid = ($urandom % 100 < 30);
    vmaRead = ($urandom % 2 == 1);
    // Mostly a single matching way, sometimes none
    r = int'($urandom % 6);
    wayValidMatch = (r < 4) ? wayVecT'(1 << r) : '0;
    wayWordValid = wayVecT'($urandom);
    wayWritten = wayVecT'($urandom);
    lruVictim = lruT'($urandom % 4);
    diagEn = ($urandom % 100 < 80);
    diagSel = diagSelT'($urandom % 4);
  endtask

  initial begin
    seedVal = $urandom(Seed);
    errCount = 0;
    checkCount = 0;
    txnCount = 0;
    cycleCount = 0;
    nRdHit = 0;
    nWrite = 0;
    nRdMiss = 0;
    nWb = 0;
    nStall = 0;
    nAux = 0;
    rstN = 1'b0;
    mbReq = 1'b0;
    chanReq = 1'b0;
    eboxReq = 1'b0;
    ccaReq = 1'b0;
    vmaRead = 1'b0;
    coreBusy = 1'b0;
    coreDataValid = 1'b0;
    wayValidMatch = '0;
    wayWordValid = '0;
    wayWritten = '0;
    lruVictim = '0;
    diagEn = 1'b1;
    diagSel = '0;
    resetModel();
    repeat (5) @(posedge clk);
    #2 rstN = 1'b1;
    #10 checkOutputs();

    // Idle state row shows only readyToGo
    @(posedge clk);
    stepModel();
    #12 checkVal("diagData", 32'(diagData), 32'h80);
    checkOutputs();

    while (txnCount < NumTxn) begin
      @(posedge clk);
      stepModel();
      #2 driveRandom(1'b1);
      #16 checkOutputs();
    end

    // Drain the last cycle and any open core read
    while (!mReady || mCoreReq) begin
      @(posedge clk);
      stepModel();
      #2 driveRandom(1'b0);
      #16 checkOutputs();
    end
    repeat (4) begin
      @(posedge clk);
      stepModel();
      #2 driveRandom(1'b0);
      #16 checkOutputs();
    end

    requireSeen("an EBOX read hit", nRdHit);
    requireSeen("a cache write", nWrite);
    requireSeen("a read miss", nRdMiss);
    requireSeen("a writeback", nWb);
    requireSeen("a coreBusy stall in t2", nStall);
    requireSeen("a non-EBOX cycle", nAux);

    $display("Transactions %0d, checks %0d, errors %0d", txnCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* cshTop.f */
+incdir+.
cshCyclePkg.sv
cshDiagPkg.sv
cshArbiter.sv
cshWayMatch.sv
cshCoreRead.sv
cshControl.sv
cshDiagMux.sv
cshTop.sv
cshTopTb.sv

/* Makefile */
TOP = cshTopTb
OBJ = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f cshTop.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f cshTop.f --top-module $(TOP) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJ)
